/* list.f */
+incdir+logic
logic/dmem_pkg.sv
logic/dmem_router.sv
logic/mtimer.sv
logic/wb_dmem_bridge.sv
logic/dmem_subsys_top.sv
verification/wb_mem_model.sv
verification/dmem_subsys_tb.sv

/* logic/dmem_config.svh */
//--------------------------------------------------------------------------
// Data memory subsystem configuration
// Bus widths, timer address window and timer register map
//--------------------------------------------------------------------------

`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// Core data port and Wishbone widths
`define DMEM_AWIDTH             32
`define DMEM_DWIDTH             32
`define DMEM_SELW               4

// Timer window, 32 bytes at the base
`define TIMER_ADDR_PATTERN      32'h00490000
`define TIMER_ADDR_MASK         32'hFFFFFFE0

// Timer register offsets inside the window
`define TIMER_CONTROL_OFFS      5'h00
`define TIMER_DIVIDER_OFFS      5'h04
`define TIMER_MTIMELO_OFFS      5'h08
`define TIMER_MTIMEHI_OFFS      5'h0C
`define TIMER_MTIMECMPLO_OFFS   5'h10
`define TIMER_MTIMECMPHI_OFFS   5'h14

`define TIMER_DIV_WIDTH         10  // Prescaler divider bits

`endif

/* logic/dmem_pkg.sv */
//--------------------------------------------------------------------------
// Data memory subsystem types
// Request command, access width, response code and router port select
//--------------------------------------------------------------------------

`include "dmem_config.svh"

package dmem_pkg;

    // Request direction
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } mem_cmd_e;

    // Access size
    typedef enum logic [1:0] {
        BYTE  = 2'b00,
        HWORD = 2'b01,
        WORD  = 2'b10
    } mem_width_e;

    // One cycle of RDY_OK or RDY_ER per accepted request
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        RDY_OK = 2'b01,
        RDY_ER = 2'b10
    } mem_resp_e;

    typedef logic [`DMEM_AWIDTH-1:0] dmem_addr_t;
    typedef logic [`DMEM_DWIDTH-1:0] dmem_data_t;

    typedef enum logic {
        PORT_WB    = 1'b0,
        PORT_TIMER = 1'b1  // Timer window hit
    } port_sel_e;

endpackage

/* logic/dmem_router.sv */
//--------------------------------------------------------------------------
// Data memory router
// Decodes the core request address, forwards the request to the timer
// or the Wishbone bridge and returns the response of the taken port.
// One request outstanding at a time.
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "dmem_config.svh"

module dmem_router (
    input  logic                    core_clk,
    input  logic                    rst_i,
    // Core side
    input  logic                    dmem_req_i,
    input  dmem_pkg::mem_cmd_e      dmem_cmd_i,
    input  dmem_pkg::mem_width_e    dmem_width_i,
    input  dmem_pkg::dmem_addr_t    dmem_addr_i,
    input  dmem_pkg::dmem_data_t    dmem_wdata_i,
    output logic                    dmem_req_ack_o,
    output dmem_pkg::dmem_data_t    dmem_rdata_o,
    output dmem_pkg::mem_resp_e     dmem_resp_o,
    // Timer port
    output logic                    timer_req_o,
    output dmem_pkg::mem_cmd_e      timer_cmd_o,
    output dmem_pkg::mem_width_e    timer_width_o,
    output dmem_pkg::dmem_addr_t    timer_addr_o,
    output dmem_pkg::dmem_data_t    timer_wdata_o,
    input  logic                    timer_req_ack_i,
    input  dmem_pkg::dmem_data_t    timer_rdata_i,
    input  dmem_pkg::mem_resp_e     timer_resp_i,
    // Wishbone bridge port
    output logic                    wb_req_o,
    output dmem_pkg::mem_cmd_e      wb_cmd_o,
    output dmem_pkg::mem_width_e    wb_width_o,
    output dmem_pkg::dmem_addr_t    wb_addr_o,
    output dmem_pkg::dmem_data_t    wb_wdata_o,
    input  logic                    wb_req_ack_i,
    input  dmem_pkg::dmem_data_t    wb_rdata_i,
    input  dmem_pkg::mem_resp_e     wb_resp_i
);

logic                   hit_timer;      // Address inside timer window
logic                   busy;           // Request outstanding
logic                   resp_done;      // Outstanding request answered now
logic                   can_accept;
logic                   accept;
dmem_pkg::port_sel_e    port_sel;       // Port of the outstanding request
dmem_pkg::port_sel_e    port_new;
dmem_pkg::mem_resp_e    sel_resp;

//--------------------------------------------------------------------------
// Request direction
//--------------------------------------------------------------------------
assign hit_timer  = ((dmem_addr_i & `TIMER_ADDR_MASK) == `TIMER_ADDR_PATTERN);
assign port_new   = hit_timer ? dmem_pkg::PORT_TIMER : dmem_pkg::PORT_WB;

// Next request may go out in the cycle the current one returns
assign can_accept = ~busy | resp_done;

assign timer_req_o    = dmem_req_i & can_accept & hit_timer;
assign wb_req_o       = dmem_req_i & can_accept & ~hit_timer;
assign dmem_req_ack_o = can_accept & (hit_timer ? timer_req_ack_i : wb_req_ack_i);
assign accept         = dmem_req_i & dmem_req_ack_o;

// Payload fans out, only req is steered
assign timer_cmd_o   = dmem_cmd_i;
assign timer_width_o = dmem_width_i;
assign timer_addr_o  = dmem_addr_i;
assign timer_wdata_o = dmem_wdata_i;
assign wb_cmd_o      = dmem_cmd_i;
assign wb_width_o    = dmem_width_i;
assign wb_addr_o     = dmem_addr_i;
assign wb_wdata_o    = dmem_wdata_i;

//--------------------------------------------------------------------------
// Response direction
//--------------------------------------------------------------------------
assign sel_resp     = (port_sel == dmem_pkg::PORT_TIMER) ? timer_resp_i : wb_resp_i;
assign resp_done    = busy & (sel_resp != dmem_pkg::IDLE);
assign dmem_resp_o  = busy ? sel_resp : dmem_pkg::IDLE;
assign dmem_rdata_o = (port_sel == dmem_pkg::PORT_TIMER) ? timer_rdata_i : wb_rdata_i;

always_ff @(posedge core_clk) begin
    if (rst_i) begin
        busy     <= 1'b0;
        port_sel <= dmem_pkg::PORT_WB;
    end else if (accept) begin
        busy     <= 1'b1;           // Also covers back-to-back accept
        port_sel <= port_new;
    end else if (resp_done) begin
        busy     <= 1'b0;
    end
end

// Targets only answer requests that this router handed them
timer_resp_recorded_a: assert property (@(posedge core_clk) disable iff (rst_i)
    (timer_resp_i != dmem_pkg::IDLE) |-> (busy && port_sel == dmem_pkg::PORT_TIMER));
wb_resp_recorded_a: assert property (@(posedge core_clk) disable iff (rst_i)
    (wb_resp_i != dmem_pkg::IDLE) |-> (busy && port_sel == dmem_pkg::PORT_WB));

endmodule

/* logic/dmem_subsys_top.sv */
//--------------------------------------------------------------------------
// Data memory subsystem top
// Core data port through the address router to the machine timer
// and the Wishbone bridge
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "dmem_config.svh"

module dmem_subsys_top (
    input  logic                        core_clk,
    input  logic                        rst_i,
    // Core data port
    input  logic                        dmem_req_i,
    input  dmem_pkg::mem_cmd_e          dmem_cmd_i,
    input  dmem_pkg::mem_width_e        dmem_width_i,
    input  dmem_pkg::dmem_addr_t        dmem_addr_i,
    input  dmem_pkg::dmem_data_t        dmem_wdata_i,
    output logic                        dmem_req_ack_o,
    output dmem_pkg::dmem_data_t        dmem_rdata_o,
    output dmem_pkg::mem_resp_e         dmem_resp_o,
    // Wishbone master
    output logic                        wbd_stb_o,
    output logic [`DMEM_AWIDTH-1:0]     wbd_adr_o,
    output logic                        wbd_we_o,
    output logic [`DMEM_DWIDTH-1:0]     wbd_dat_o,
    output logic [`DMEM_SELW-1:0]       wbd_sel_o,
    input  logic [`DMEM_DWIDTH-1:0]     wbd_dat_i,
    input  logic                        wbd_ack_i,
    input  logic                        wbd_err_i,
    // Timer
    output logic                        timer_irq_o,
    output logic [63:0]                 timer_val_o
);

// Router to timer
logic                   timer_req, timer_req_ack;
dmem_pkg::mem_cmd_e     timer_cmd;
dmem_pkg::mem_width_e   timer_width;
dmem_pkg::dmem_addr_t   timer_addr;
dmem_pkg::dmem_data_t   timer_wdata, timer_rdata;
dmem_pkg::mem_resp_e    timer_resp;

// Router to Wishbone bridge
logic                   wb_req, wb_req_ack;
dmem_pkg::mem_cmd_e     wb_cmd;
dmem_pkg::mem_width_e   wb_width;
dmem_pkg::dmem_addr_t   wb_addr;
dmem_pkg::dmem_data_t   wb_wdata, wb_rdata;
dmem_pkg::mem_resp_e    wb_resp;

dmem_router i_dmem_router (
    .core_clk        (core_clk       ),
    .rst_i           (rst_i          ),
    .dmem_req_i      (dmem_req_i     ),
    .dmem_cmd_i      (dmem_cmd_i     ),
    .dmem_width_i    (dmem_width_i   ),
    .dmem_addr_i     (dmem_addr_i    ),
    .dmem_wdata_i    (dmem_wdata_i   ),
    .dmem_req_ack_o  (dmem_req_ack_o ),
    .dmem_rdata_o    (dmem_rdata_o   ),
    .dmem_resp_o     (dmem_resp_o    ),
    .timer_req_o     (timer_req      ),
    .timer_cmd_o     (timer_cmd      ),
    .timer_width_o   (timer_width    ),
    .timer_addr_o    (timer_addr     ),
    .timer_wdata_o   (timer_wdata    ),
    .timer_req_ack_i (timer_req_ack  ),
    .timer_rdata_i   (timer_rdata    ),
    .timer_resp_i    (timer_resp     ),
    .wb_req_o        (wb_req         ),
    .wb_cmd_o        (wb_cmd         ),
    .wb_width_o      (wb_width       ),
    .wb_addr_o       (wb_addr        ),
    .wb_wdata_o      (wb_wdata       ),
    .wb_req_ack_i    (wb_req_ack     ),
    .wb_rdata_i      (wb_rdata       ),
    .wb_resp_i       (wb_resp        )
);

mtimer i_timer (
    .core_clk    (core_clk     ),
    .rst_i       (rst_i        ),
    .req_i       (timer_req    ),
    .cmd_i       (timer_cmd    ),
    .width_i     (timer_width  ),
    .addr_i      (timer_addr   ),
    .wdata_i     (timer_wdata  ),
    .req_ack_o   (timer_req_ack),
    .rdata_o     (timer_rdata  ),
    .resp_o      (timer_resp   ),
    .timer_val_o (timer_val_o  ),
    .timer_irq_o (timer_irq_o  )
);

wb_dmem_bridge i_dmem_wb (
    .core_clk  (core_clk  ),
    .rst_i     (rst_i     ),
    .req_i     (wb_req    ),
    .cmd_i     (wb_cmd    ),
    .width_i   (wb_width  ),
    .addr_i    (wb_addr   ),
    .wdata_i   (wb_wdata  ),
    .req_ack_o (wb_req_ack),
    .rdata_o   (wb_rdata  ),
    .resp_o    (wb_resp   ),
    .wbd_stb_o (wbd_stb_o ),
    .wbd_adr_o (wbd_adr_o ),
    .wbd_we_o  (wbd_we_o  ),
    .wbd_dat_o (wbd_dat_o ),
    .wbd_sel_o (wbd_sel_o ),
    .wbd_dat_i (wbd_dat_i ),
    .wbd_ack_i (wbd_ack_i ),
    .wbd_err_i (wbd_err_i )
);

endmodule

/* logic/mtimer.sv */
//--------------------------------------------------------------------------
// Memory-mapped machine timer
// Control, divider, mtime and mtimecmp registers on the data port.
// mtime counts prescaled core clock ticks while enabled; the interrupt
// is raised when mtime reaches mtimecmp.
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "dmem_config.svh"

module mtimer (
    input  logic                    core_clk,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  dmem_pkg::mem_cmd_e      cmd_i,
    input  dmem_pkg::mem_width_e    width_i,
    input  dmem_pkg::dmem_addr_t    addr_i,
    input  dmem_pkg::dmem_data_t    wdata_i,
    output logic                    req_ack_o,
    output dmem_pkg::dmem_data_t    rdata_o,
    output dmem_pkg::mem_resp_e     resp_o,
    output logic [63:0]             timer_val_o,
    output logic                    timer_irq_o
);

logic                           enable;     // Control bit 0
logic [`TIMER_DIV_WIDTH-1:0]    divider;
logic [`TIMER_DIV_WIDTH-1:0]    div_cnt;    // Prescaler count
logic [63:0]                    mtime;
logic [63:0]                    mtimecmp;
logic [4:0]                     offs;
logic                           offs_ok;    // Mapped register
logic                           accept;
logic                           wr_en;
logic                           tick;       // mtime increment strobe
dmem_pkg::dmem_data_t           rd_val;

assign req_ack_o = req_i;                   // Always ready
assign accept    = req_i & req_ack_o;
assign offs      = addr_i[4:0];

//--------------------------------------------------------------------------
// Register decode
//--------------------------------------------------------------------------
always_comb begin
    offs_ok = 1'b1;
    rd_val  = '0;
    case (offs)
        `TIMER_CONTROL_OFFS:    rd_val = dmem_pkg::dmem_data_t'(enable);
        `TIMER_DIVIDER_OFFS:    rd_val = dmem_pkg::dmem_data_t'(divider);
        `TIMER_MTIMELO_OFFS:    rd_val = mtime[31:0];
        `TIMER_MTIMEHI_OFFS:    rd_val = mtime[63:32];
        `TIMER_MTIMECMPLO_OFFS: rd_val = mtimecmp[31:0];
        `TIMER_MTIMECMPHI_OFFS: rd_val = mtimecmp[63:32];
        default:                offs_ok = 1'b0;     // Unmapped offset answers an error
    endcase
end

// Word writes to mapped offsets only
assign wr_en = accept & (cmd_i == dmem_pkg::WRITE) & (width_i == dmem_pkg::WORD) & offs_ok;

//--------------------------------------------------------------------------
// Prescaler and registers
//--------------------------------------------------------------------------
assign tick = enable & (div_cnt == divider);   // Every divider+1 cycles

always_ff @(posedge core_clk) begin
    if (rst_i) begin
        div_cnt <= '0;
    end else if (!enable || tick) begin
        div_cnt <= '0;
    end else begin
        div_cnt <= div_cnt + 1'b1;
    end
end

always_ff @(posedge core_clk) begin
    if (rst_i) begin
        enable   <= 1'b0;
        divider  <= '0;
        mtime    <= '0;
        mtimecmp <= '0;
    end else begin
        if (tick) begin
            mtime <= mtime + 64'd1;
        end
        if (wr_en) begin
            case (offs)     // Write wins over the count for its half
                `TIMER_CONTROL_OFFS:    enable          <= wdata_i[0];
                `TIMER_DIVIDER_OFFS:    divider         <= wdata_i[`TIMER_DIV_WIDTH-1:0];
                `TIMER_MTIMELO_OFFS:    mtime[31:0]     <= wdata_i;
                `TIMER_MTIMEHI_OFFS:    mtime[63:32]    <= wdata_i;
                `TIMER_MTIMECMPLO_OFFS: mtimecmp[31:0]  <= wdata_i;
                `TIMER_MTIMECMPHI_OFFS: mtimecmp[63:32] <= wdata_i;
                default: ;
            endcase
        end
    end
end

//--------------------------------------------------------------------------
// Response one cycle after acceptance
//--------------------------------------------------------------------------
always_ff @(posedge core_clk) begin
    if (rst_i) begin
        resp_o <= dmem_pkg::IDLE;
    end else if (accept) begin
        resp_o <= (offs_ok && width_i == dmem_pkg::WORD) ? dmem_pkg::RDY_OK
                                                          : dmem_pkg::RDY_ER;
    end else begin
        resp_o <= dmem_pkg::IDLE;
    end
end

always_ff @(posedge core_clk) begin
    if (accept && cmd_i == dmem_pkg::READ) begin
        rdata_o <= rd_val;
    end
end

// Interrupt level
always_ff @(posedge core_clk) begin
    if (rst_i) begin
        timer_irq_o <= 1'b0;
    end else begin
        timer_irq_o <= enable & (mtime >= mtimecmp);
    end
end

assign timer_val_o = mtime;

endmodule

/* logic/wb_dmem_bridge.sv */
//--------------------------------------------------------------------------
// Data memory to Wishbone bridge
// Turns one accepted request into a single-beat Wishbone cycle with
// byte selects and lane placement. Misaligned accesses are refused
// without a bus cycle.
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "dmem_config.svh"

module wb_dmem_bridge (
    input  logic                        core_clk,
    input  logic                        rst_i,
    // Router side
    input  logic                        req_i,
    input  dmem_pkg::mem_cmd_e          cmd_i,
    input  dmem_pkg::mem_width_e        width_i,
    input  dmem_pkg::dmem_addr_t        addr_i,
    input  dmem_pkg::dmem_data_t        wdata_i,
    output logic                        req_ack_o,
    output dmem_pkg::dmem_data_t        rdata_o,
    output dmem_pkg::mem_resp_e         resp_o,
    // Wishbone master, stb doubles as cyc
    output logic                        wbd_stb_o,
    output logic [`DMEM_AWIDTH-1:0]     wbd_adr_o,
    output logic                        wbd_we_o,
    output logic [`DMEM_DWIDTH-1:0]     wbd_dat_o,
    output logic [`DMEM_SELW-1:0]       wbd_sel_o,
    input  logic [`DMEM_DWIDTH-1:0]     wbd_dat_i,
    input  logic                        wbd_ack_i,
    input  logic                        wbd_err_i
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,     // stb high, waiting for ack or err
    ST_RESP     // Response cycle
} state_e;

state_e                     state;
logic [`DMEM_SELW-1:0]      sel_new;
logic                       misaligned;
logic                       accept;
dmem_pkg::mem_resp_e        resp_q;

assign req_ack_o = (state == ST_IDLE);
assign accept    = req_i & req_ack_o;

// Byte selects and alignment check
always_comb begin
    misaligned = 1'b0;
    case (width_i)
        dmem_pkg::BYTE:  sel_new = `DMEM_SELW'(1) << addr_i[1:0];
        dmem_pkg::HWORD: begin
            sel_new    = `DMEM_SELW'(3) << addr_i[1:0];
            misaligned = addr_i[0];
        end
        dmem_pkg::WORD:  begin
            sel_new    = '1;
            misaligned = |addr_i[1:0];
        end
        default: begin                  // Reserved width code
            sel_new    = '0;
            misaligned = 1'b1;
        end
    endcase
end

//--------------------------------------------------------------------------
// Control FSM
//--------------------------------------------------------------------------
always_ff @(posedge core_clk) begin
    if (rst_i) begin
        state     <= ST_IDLE;
        wbd_stb_o <= 1'b0;
        resp_q    <= dmem_pkg::IDLE;
    end else begin
        case (state)
            ST_IDLE: if (accept) begin
                if (misaligned) begin
                    state  <= ST_RESP;          // No bus cycle
                    resp_q <= dmem_pkg::RDY_ER;
                end else begin
                    state     <= ST_BUS;
                    wbd_stb_o <= 1'b1;
                end
            end
            ST_BUS: if (wbd_ack_i || wbd_err_i) begin
                state     <= ST_RESP;
                wbd_stb_o <= 1'b0;
                resp_q    <= wbd_err_i ? dmem_pkg::RDY_ER : dmem_pkg::RDY_OK;
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// Bus payload, held for the whole cycle
always_ff @(posedge core_clk) begin
    if (accept) begin
        wbd_adr_o <= {addr_i[`DMEM_AWIDTH-1:2], 2'b00};    // Word aligned
        wbd_we_o  <= (cmd_i == dmem_pkg::WRITE);
        wbd_dat_o <= wdata_i << {addr_i[1:0], 3'b000};      // Lane placement
        wbd_sel_o <= sel_new;
    end
    if (wbd_stb_o && (wbd_ack_i || wbd_err_i)) begin
        rdata_o <= wbd_dat_i;                               // Unshifted
    end
end

assign resp_o = (state == ST_RESP) ? resp_q : dmem_pkg::IDLE;

wb_stable_a: assert property (@(posedge core_clk) disable iff (rst_i)
    (wbd_stb_o && !wbd_ack_i && !wbd_err_i) |=>
        (wbd_stb_o && $stable(wbd_adr_o) && $stable(wbd_we_o)
         && $stable(wbd_dat_o) && $stable(wbd_sel_o)));

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the data memory subsystem testbench with Verilator.
# Pass or fail is decided by the pass message in the simulator output.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module dmem_subsys_tb \
    -Mdir obj_dir

output=$(./obj_dir/Vdmem_subsys_tb 2>&1) || true
echo "$output"

if grep -qF "*** PASSED ***" <<< "$output"; then
    exit 0
fi
exit 1

/* verification/dmem_subsys_tb.sv */
//--------------------------------------------------------------------------
// Data memory subsystem testbench
// Applies a table of timer and Wishbone transactions to the top level,
// with a Wishbone memory model behind the bridge, and checks responses,
// read data, byte selects, bus cycles and the timer outputs
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "dmem_config.svh"

module dmem_subsys_tb;

localparam int CLK_PERIOD     = 8;
localparam int RST_CYCLES     = 3;
localparam int CYCLES_PER_TXN = 64;

// Extra checks per table entry
localparam int F_RD   = 1;      // Read data
localparam int F_SEL  = 2;      // Byte selects seen by the memory model
localparam int F_IRQ1 = 4;      // Interrupt high
localparam int F_IRQ0 = 8;      // Interrupt low
localparam int F_TVAL = 16;     // timer_val_o half equals the read data

localparam dmem_pkg::mem_cmd_e   RD = dmem_pkg::READ;
localparam dmem_pkg::mem_cmd_e   WR = dmem_pkg::WRITE;
localparam dmem_pkg::mem_width_e B  = dmem_pkg::BYTE;
localparam dmem_pkg::mem_width_e H  = dmem_pkg::HWORD;
localparam dmem_pkg::mem_width_e W  = dmem_pkg::WORD;
localparam dmem_pkg::mem_resp_e  OK = dmem_pkg::RDY_OK;
localparam dmem_pkg::mem_resp_e  ER = dmem_pkg::RDY_ER;

typedef struct {
    dmem_pkg::mem_cmd_e     cmd;
    dmem_pkg::mem_width_e   width;
    dmem_pkg::dmem_addr_t   addr;
    dmem_pkg::dmem_data_t   wdata;
    dmem_pkg::mem_resp_e    resp;
    dmem_pkg::dmem_data_t   rdata;
    logic [`DMEM_SELW-1:0]  sel;
    int                     bus;        // Wishbone cycles expected
    int                     flags;
} txn_t;

txn_t                   txn_q[$];
logic                   clk;
logic                   rst;
logic                   dmem_req;
dmem_pkg::mem_cmd_e     dmem_cmd;
dmem_pkg::mem_width_e   dmem_width;
dmem_pkg::dmem_addr_t   dmem_addr;
dmem_pkg::dmem_data_t   dmem_wdata;
logic                   dmem_req_ack;
dmem_pkg::dmem_data_t   dmem_rdata;
dmem_pkg::mem_resp_e    dmem_resp;
logic                   wbd_stb, wbd_we, wbd_ack, wbd_err;
logic [31:0]            wbd_adr, wbd_dat_o, wbd_dat_i;
logic [3:0]             wbd_sel, last_sel;
logic                   timer_irq;
logic [63:0]            timer_val;
int                     bus_cycles;
int                     resp_count;

dmem_subsys_top dut_i (
    .core_clk       (clk),          .rst_i          (rst),
    .dmem_req_i     (dmem_req),     .dmem_cmd_i     (dmem_cmd),
    .dmem_width_i   (dmem_width),   .dmem_addr_i    (dmem_addr),
    .dmem_wdata_i   (dmem_wdata),   .dmem_req_ack_o (dmem_req_ack),
    .dmem_rdata_o   (dmem_rdata),   .dmem_resp_o    (dmem_resp),
    .wbd_stb_o      (wbd_stb),      .wbd_adr_o      (wbd_adr),
    .wbd_we_o       (wbd_we),       .wbd_dat_o      (wbd_dat_o),
    .wbd_sel_o      (wbd_sel),      .wbd_dat_i      (wbd_dat_i),
    .wbd_ack_i      (wbd_ack),      .wbd_err_i      (wbd_err),
    .timer_irq_o    (timer_irq),    .timer_val_o    (timer_val)
);

wb_mem_model wb_mem (
    .clk_i (clk),       .rst_i (rst),       .stb_i (wbd_stb),   .adr_i (wbd_adr),
    .we_i  (wbd_we),    .dat_i (wbd_dat_o), .sel_i (wbd_sel),   .dat_o (wbd_dat_i),
    .ack_o (wbd_ack),   .err_o (wbd_err),   .last_sel_o (last_sel),
    .cycles_o (bus_cycles)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// Compares a DUT value with its expected value
task automatic check_equal(input string what, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    end
endtask

function automatic dmem_pkg::dmem_addr_t timer_reg(input logic [4:0] offs);
    return `TIMER_ADDR_PATTERN | {27'd0, offs};
endfunction

task automatic add_txn(input dmem_pkg::mem_cmd_e cmd, input dmem_pkg::mem_width_e width,
                       input logic [31:0] addr, input logic [31:0] wdata,
                       input dmem_pkg::mem_resp_e resp, input logic [31:0] rdata,
                       input logic [3:0] sel, input int bus, input int flags);
    txn_t e;
    e = '{cmd, width, addr, wdata, resp, rdata, sel, bus, flags};
    txn_q.push_back(e);
endtask

// Entered and left on a falling edge
task automatic run_txn(input int idx);
    txn_t   e;
    int     bus_before;
    logic   accepted;
    string  tag;
    e          = txn_q[idx];
    tag        = $sformatf("txn %0d", idx);
    bus_before = bus_cycles;
    dmem_req   = 1'b1;
    dmem_cmd   = e.cmd;
    dmem_width = e.width;
    dmem_addr  = e.addr;
    dmem_wdata = e.wdata;
    accepted   = 1'b0;
    while (!accepted) begin
        #1;                             // Ack settles before the rising edge
        accepted = dmem_req_ack;
        @(negedge clk);
    end
    dmem_req = 1'b0;
    while (dmem_resp == dmem_pkg::IDLE) @(negedge clk);
    check_equal({tag, " resp"}, 64'(dmem_resp), 64'(e.resp));
    check_equal({tag, " bus cycles"}, 64'(bus_cycles - bus_before), 64'(e.bus));
    if ((e.flags & F_RD) != 0) check_equal({tag, " rdata"}, 64'(dmem_rdata), 64'(e.rdata));
    if ((e.flags & F_SEL) != 0) check_equal({tag, " sel"}, 64'(last_sel), 64'(e.sel));
    if ((e.flags & F_IRQ1) != 0) check_equal({tag, " irq"}, 64'(timer_irq), 64'd1);
    if ((e.flags & F_IRQ0) != 0) check_equal({tag, " irq"}, 64'(timer_irq), 64'd0);
    if ((e.flags & F_TVAL) != 0) begin
        check_equal({tag, " timer_val_o"},
                    e.addr[2] ? 64'(timer_val[63:32]) : 64'(timer_val[31:0]), 64'(e.rdata));
    end
    @(negedge clk);
    check_equal({tag, " single response"}, 64'(dmem_resp), 64'(dmem_pkg::IDLE));
endtask

// Responses seen on the core port
always @(negedge clk) begin
    if (rst) resp_count <= 0;
    else if (dmem_resp != dmem_pkg::IDLE) resp_count <= resp_count + 1;
end

// Bus address is the word address of the held request
always @(negedge clk) begin
    if (!rst && wbd_stb) begin
        check_equal("wbd_adr_o", 64'(wbd_adr), 64'(dmem_addr & ~32'h3));
        check_equal("wbd_we_o", 64'(wbd_we), 64'(dmem_cmd == dmem_pkg::WRITE));
    end
end

initial begin : watchdog
    int limit;
    #1;                                 // Table is built at time zero
    limit = RST_CYCLES + CYCLES_PER_TXN * txn_q.size();
    repeat (limit) @(posedge clk);
    $display("Timeout: no progress within %0d cycles", limit);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
end

initial begin : stimulus
    rst        = 1'b1;
    dmem_req   = 1'b0;
    dmem_cmd   = dmem_pkg::READ;
    dmem_width = dmem_pkg::WORD;
    dmem_addr  = '0;
    dmem_wdata = '0;
    resp_count = 0;
    //----------------------------------------------------------------------
    // Wishbone memory at word index 0..2
    //----------------------------------------------------------------------
    add_txn(WR, W, 32'h0000_0100, 32'h1234_5678, OK, 32'h0, 4'hF, 1, F_SEL);
    add_txn(RD, W, 32'h0000_0100, 32'h0, OK, 32'h1234_5678, 4'hF, 1, F_RD);
    add_txn(WR, W, 32'h0000_0104, 32'hAABB_CCDD, OK, 32'h0, 4'hF, 1, F_SEL);
    add_txn(WR, B, 32'h0000_0106, 32'h0000_00EE, OK, 32'h0, 4'h4, 1, F_SEL);   // Lane 2
    add_txn(RD, W, 32'h0000_0104, 32'h0, OK, 32'hAAEE_CCDD, 4'hF, 1, F_RD);
    add_txn(WR, W, 32'h0000_0108, 32'h5566_7788, OK, 32'h0, 4'hF, 1, F_SEL);
    add_txn(WR, H, 32'h0000_010A, 32'h0000_1122, OK, 32'h0, 4'hC, 1, F_SEL);   // Upper half
    add_txn(RD, W, 32'h0000_0108, 32'h0, OK, 32'h1122_7788, 4'hF, 1, F_RD);
    add_txn(WR, B, 32'h0000_0103, 32'h0000_005A, OK, 32'h0, 4'h8, 1, F_SEL);
    add_txn(RD, W, 32'h0000_0100, 32'h0, OK, 32'h5A34_5678, 4'hF, 1, F_RD);
    // Misaligned accesses refused without a bus cycle
    add_txn(WR, H, 32'h0000_0101, 32'h0000_BEEF, ER, 32'h0, 4'h0, 0, 0);
    add_txn(RD, W, 32'h0000_0102, 32'h0, ER, 32'h0, 4'h0, 0, 0);
    // Error window bus cycles end in err
    add_txn(RD, W, 32'hE000_0010, 32'h0, ER, 32'h0, 4'h0, 1, 0);
    add_txn(WR, W, 32'hE000_0014, 32'hDEAD_BEEF, ER, 32'h0, 4'hF, 1, F_SEL);
    add_txn(RD, W, 32'h0000_0104, 32'h0, OK, 32'hAAEE_CCDD, 4'hF, 1, F_RD);
    //----------------------------------------------------------------------
    // Timer registers and interrupt
    //----------------------------------------------------------------------
    add_txn(WR, W, timer_reg(`TIMER_DIVIDER_OFFS), 32'h155, OK, 32'h0, 4'h0, 0, 0);
    add_txn(RD, W, timer_reg(`TIMER_DIVIDER_OFFS), 32'h0, OK, 32'h155, 4'h0, 0, F_RD);
    add_txn(RD, H, timer_reg(`TIMER_DIVIDER_OFFS), 32'h0, ER, 32'h0, 4'h0, 0, 0);
    add_txn(WR, W, timer_reg(5'h18), 32'h1, ER, 32'h0, 4'h0, 0, 0);             // Unmapped
    add_txn(WR, W, timer_reg(`TIMER_DIVIDER_OFFS), 32'h0, OK, 32'h0, 4'h0, 0, 0);
    add_txn(WR, W, timer_reg(`TIMER_MTIMECMPLO_OFFS), 32'h0, OK, 32'h0, 4'h0, 0, 0);
    add_txn(WR, W, timer_reg(`TIMER_CONTROL_OFFS), 32'h1, OK, 32'h0, 4'h0, 0, 0);
    add_txn(RD, W, timer_reg(`TIMER_CONTROL_OFFS), 32'h0, OK, 32'h1, 4'h0, 0, F_RD | F_IRQ1);
    add_txn(WR, W, timer_reg(`TIMER_MTIMECMPHI_OFFS), 32'hFFFF_FFFF, OK, 32'h0, 4'h0, 0, 0);
    add_txn(WR, W, timer_reg(`TIMER_CONTROL_OFFS), 32'h0, OK, 32'h0, 4'h0, 0, F_IRQ0);
    add_txn(WR, W, timer_reg(`TIMER_MTIMELO_OFFS), 32'h1357_9BDF, OK, 32'h0, 4'h0, 0, 0);
    add_txn(WR, W, timer_reg(`TIMER_MTIMEHI_OFFS), 32'h2468_ACE0, OK, 32'h0, 4'h0, 0, 0);
    add_txn(RD, W, timer_reg(`TIMER_MTIMELO_OFFS), 32'h0, OK, 32'h1357_9BDF, 4'h0, 0,
            F_RD | F_TVAL);
    add_txn(RD, W, timer_reg(`TIMER_MTIMEHI_OFFS), 32'h0, OK, 32'h2468_ACE0, 4'h0, 0,
            F_RD | F_TVAL | F_IRQ0);
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_equal("irq after reset", 64'(timer_irq), 64'd0);
    check_equal("stb after reset", 64'(wbd_stb), 64'd0);
    for (int i = 0; i < txn_q.size(); i++) begin
        run_txn(i);
    end
    repeat (4) @(negedge clk);
    check_equal("response count", 64'(resp_count), 64'(txn_q.size()));
    $display("*** PASSED ***");
    $finish;
end

endmodule

/* verification/wb_mem_model.sv */
//--------------------------------------------------------------------------
// Wishbone slave memory model
// 16 words behind a single-beat Wishbone port. Ack follows after 0 to 3
// cycles drawn from an LFSR, err instead inside the 0xE000_0000 window.
// Counts bus cycles and keeps the byte selects of the latest one.
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module wb_mem_model (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stb_i,
    input  logic [31:0] adr_i,
    input  logic        we_i,
    input  logic [31:0] dat_i,
    input  logic [3:0]  sel_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    output logic        err_o,
    output logic [3:0]  last_sel_o,     // Byte selects of the latest cycle
    output int          cycles_o        // Bus cycles started so far
);

logic [31:0] mem [0:15];
logic [15:0] lfsr;                      // Delay source, seed 98
logic        active;                    // Cycle seen, ack not yet given
logic [1:0]  delay;                     // Cycles left before ack

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// Byte lane merge for partial writes
function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                            input logic [31:0] new_w,
                                            input logic [3:0]  sel);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
        if (sel[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
endfunction

initial begin
    dat_o      = '0;
    ack_o      = 1'b0;
    err_o      = 1'b0;
    last_sel_o = '0;
    cycles_o   = 0;
    active     = 1'b0;
    delay      = '0;
    lfsr       = 16'd98;
    for (int i = 0; i < 16; i++) begin
        mem[i] = {16'hC0DE, 12'h000, i[3:0]};   // Fill tagged by word index
    end
end

// Outputs change on the falling edge, the bridge samples on the rising one
always @(negedge clk_i) begin
    if (rst_i) begin
        ack_o  <= 1'b0;
        err_o  <= 1'b0;
        active = 1'b0;
    end else if (ack_o || err_o) begin
        ack_o  <= 1'b0;                 // Single-cycle handshake
        err_o  <= 1'b0;
        active = 1'b0;
    end else if (stb_i) begin
        if (!active) begin
            lfsr       = lfsr_next(lfsr);           // One step per bit
            delay      = {1'b0, lfsr[0]};
            lfsr       = lfsr_next(lfsr);
            delay      = {delay[0], lfsr[0]};
            active     = 1'b1;
            cycles_o   <= cycles_o + 1;
            last_sel_o <= sel_i;
        end
        if (delay != 2'd0) begin
            delay = delay - 2'd1;       // Back-pressure
        end else if (adr_i[31:28] == 4'hE) begin
            err_o <= 1'b1;              // Error window
        end else begin
            ack_o <= 1'b1;
            if (we_i) begin
                mem[adr_i[5:2]] = merge_bytes(mem[adr_i[5:2]], dat_i, sel_i);
            end else begin
                dat_o <= mem[adr_i[5:2]];
            end
        end
    end
end

endmodule
